// ==== flist.f ====
src/clkPkg.sv
src/pllLockDetect.sv
src/clkSwitch.sv
src/clkRelease.sv
src/clkTop.sv
test/clkTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the clock-control testbench with Verilator and runs it.
# The log is searched for the fail message to decide the result.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module clkTb -f flist.f -o clkSim

# A simulator error stops the script here through set -e
./obj_dir/clkSim > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== src/clkPkg.sv ====
/*
 * Shared definitions for the clock-control subsystem.
 * Holds the clock-source select encoding, the lock detector states
 * and the width of the feedback divider input.
 * Modules take these by a wildcard import in their header.
 */
package clkPkg;

    // ==========================================================
    // Divider
    // ==========================================================

    // Feedback divider input width
    localparam int FBDIV_WIDTH = 5;

    // ==========================================================
    // Clock source select
    // ==========================================================

    // Values double as bit index into per-source vectors
    typedef enum logic [1:0] {
        srcOff = 2'd0,
        srcSys = 2'd1,
        srcPll = 2'd2
    } clkSrcE;

    // ==========================================================
    // Lock detector states
    // ==========================================================

    typedef enum logic [1:0] {
        // No good window seen yet
        lkIdle    = 2'd0,
        // Run of good windows in progress
        lkMeasure = 2'd1,
        // Enough good windows in a row
        lkLocked  = 2'd2
    } lockStateE;

endpackage

// ==== src/clkRelease.sv ====
/*
 * Software clock release for one clock domain.
 * swClk is synchronized on the rising edge of clkIn and moved into the
 * gate on the falling edge, so clkOut only starts or stops between
 * pulses. The gate is closed while rstN is low.
 */
`timescale 1ns/1ns
module clkRelease (
    input  logic clkIn,
    input  logic rstN,
    input  logic swClk,
    output logic clkOut
);

    logic [1:0] swSync;
    logic       gateQ;

    // ==========================================================
    // Enable sync and gate
    // ==========================================================

    always_ff @(posedge clkIn or negedge rstN) begin
        if (!rstN) begin
            swSync <= '0;
        end else begin
            swSync <= {swSync[0], swClk};
        end
    end

    // Gate moves only in the low phase
    always_ff @(negedge clkIn or negedge rstN) begin
        if (!rstN) begin
            gateQ <= 1'b0;
        end else begin
            gateQ <= swSync[1];
        end
    end

    assign clkOut = clkIn & gateQ;

    // Every output pulse starts with the gate already open
    assert property (@(posedge clkOut) disable iff (!rstN) gateQ)
        else $error("clkRelease output edge with gate closed");

endmodule

// ==== src/clkSwitch.sv ====
/*
 * Glitch-free three-way clock multiplexer.
 * The requested source follows bypAsyncFifo, bypPll and the lock level
 * in that priority. Each source has a two-flop enable chain on the
 * falling edge of its own clock, and a chain only starts once every
 * other chain reads low. clkSrc follows the enable that is high.
 */
`timescale 1ns/1ns
module clkSwitch import clkPkg::*; (
    input  logic   sysClk,
    input  logic   offClk,
    input  logic   vcoClk,
    input  logic   rstN,
    input  logic   bypAsyncFifo,
    input  logic   bypPll,
    input  logic   lockLevel,
    output logic   muxClk,
    output clkSrcE clkSrc
);

    localparam int NumSrc = 3;

    clkSrcE            reqSrc;
    logic [NumSrc-1:0] srcClk;
    logic [NumSrc-1:0] reqVec;
    // First and second stage of each enable chain
    logic [NumSrc-1:0] stgVec;
    logic [NumSrc-1:0] enVec;
    logic [NumSrc-1:0] busyVec;
    clkSrcE            curSrc;
    clkSrcE            lastSrc;

    // ==========================================================
    // Source request
    // ==========================================================

    always_comb begin
        if (bypAsyncFifo) begin
            reqSrc = srcOff;
        end else if (bypPll || !lockLevel) begin
            reqSrc = srcSys;
        end else begin
            reqSrc = srcPll;
        end
    end

    // Bit positions follow the enum values
    assign srcClk[srcOff] = offClk;
    assign srcClk[srcSys] = sysClk;
    assign srcClk[srcPll] = vcoClk;

    assign reqVec  = NumSrc'(1) << reqSrc;
    // A chain counts as busy from its first stage on
    assign busyVec = stgVec | enVec;

    // ==========================================================
    // Enable chains
    // ==========================================================

    for (genvar i = 0; i < NumSrc; i++) begin : genSrc
        logic otherBusy;
        logic stg;
        logic en;

        assign otherBusy = |(busyVec & ~(NumSrc'(1) << i));

        // Falling edge so the enable moves while the clock is low
        always_ff @(negedge srcClk[i] or negedge rstN) begin
            if (!rstN) begin
                // Reset starts on the reference clock
                stg <= (i == int'(srcSys));
                en  <= (i == int'(srcSys));
            end else begin
                stg <= reqVec[i] && !otherBusy;
                en  <= stg;
            end
        end

        assign stgVec[i] = stg;
        assign enVec[i]  = en;
    end

    assign muxClk = |(srcClk & enVec);

    // ==========================================================
    // Reported source
    // ==========================================================

    always_comb begin
        if (enVec[srcOff]) begin
            curSrc = srcOff;
        end else if (enVec[srcPll]) begin
            curSrc = srcPll;
        end else if (enVec[srcSys]) begin
            curSrc = srcSys;
        end else begin
            // Gap between old and new enable
            curSrc = lastSrc;
        end
    end

    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            lastSrc <= srcSys;
        end else begin
            lastSrc <= curSrc;
        end
    end

    assign clkSrc = curSrc;

    // Cross-disable across three clock domains keeps one clock at most
    assert property (@(posedge sysClk) disable iff (!rstN) $onehot0(enVec))
        else $error("clkSwitch more than one source enabled");

endmodule

// ==== src/clkTop.sv ====
/*
 * Clock-control top level.
 * Connects the PLL lock detector, the glitch-free source switch and
 * two software clock releases, one for the system clock output and
 * one for the off-chip clock output. Sets the detector window
 * parameters and passes the divider width down.
 */
`timescale 1ns/1ns
module clkTop import clkPkg::*; #(
    parameter int FbDivWidth  = FBDIV_WIDTH,
    parameter int RefWindow   = 16,
    parameter int LockWindows = 4
) (
    input  logic                  sysClk,
    input  logic                  rstN,
    input  logic                  offClk,
    input  logic                  vcoClk,
    input  logic                  bypAsyncFifo,
    input  logic                  bypPll,
    input  logic                  swClk,
    input  logic [FbDivWidth-1:0] fbDiv,
    output logic                  sysClkOut,
    output logic                  offClkOut,
    output logic                  pllLock,
    output clkSrcE                clkSrc
);

    // Lock level that also drives pllLock
    logic lockLevel;
    // Selected clock ahead of its release gate
    logic muxClk;

    // ==========================================================
    // Lock detection and source switch
    // ==========================================================

    pllLockDetect #(
        .FbDivWidth  (FbDivWidth),
        .RefWindow   (RefWindow),
        .LockWindows (LockWindows)
    ) lockDet (
        .sysClk    (sysClk),
        .vcoClk    (vcoClk),
        .rstN      (rstN),
        .fbDiv     (fbDiv),
        .lockLevel (lockLevel)
    );

    clkSwitch clkSw (
        .sysClk       (sysClk),
        .offClk       (offClk),
        .vcoClk       (vcoClk),
        .rstN         (rstN),
        .bypAsyncFifo (bypAsyncFifo),
        .bypPll       (bypPll),
        .lockLevel    (lockLevel),
        .muxClk       (muxClk),
        .clkSrc       (clkSrc)
    );

    assign pllLock = lockLevel;

    // ==========================================================
    // Output releases
    // ==========================================================

    clkRelease relSys (
        .clkIn  (muxClk),
        .rstN   (rstN),
        .swClk  (swClk),
        .clkOut (sysClkOut)
    );

    clkRelease relOff (
        .clkIn  (offClk),
        .rstN   (rstN),
        .swClk  (swClk),
        .clkOut (offClkOut)
    );

endmodule

// ==== src/pllLockDetect.sv ====
/*
 * Digital PLL lock detector.
 * A window toggle in the sysClk domain marks reference windows of
 * RefWindow cycles. The VCO domain counts its own cycles per window and
 * compares the count with fbDiv * RefWindow. After LockWindows good
 * windows in a row the lock level rises, and one bad window clears it.
 * The lock level is handed back to sysClk through two flops.
 */
`timescale 1ns/1ns
module pllLockDetect import clkPkg::*; #(
    parameter int FbDivWidth  = FBDIV_WIDTH,
    parameter int RefWindow   = 16,
    parameter int LockWindows = 4
) (
    input  logic                  sysClk,
    input  logic                  vcoClk,
    input  logic                  rstN,
    input  logic [FbDivWidth-1:0] fbDiv,
    output logic                  lockLevel
);

    localparam int RefCntWidth  = (RefWindow > 1) ? $clog2(RefWindow) : 1;
    // Room for a VCO well above the expected rate before saturation
    localparam int VcoCntWidth  = FbDivWidth + $clog2(RefWindow + 1) + 2;
    localparam int GoodCntWidth = $clog2(LockWindows + 1);

    // Reference side
    logic [RefCntWidth-1:0]  refCnt;
    logic                    winTgl;

    // VCO side
    logic [1:0]              tglSync;
    logic                    tglSyncD;
    logic                    winEdge;
    logic [VcoCntWidth-1:0]  vcoCnt;
    logic [VcoCntWidth-1:0]  winCount;
    logic [VcoCntWidth-1:0]  expCount;
    logic                    winGood;
    logic                    winArmed;
    lockStateE               lkState;
    logic [GoodCntWidth-1:0] goodCnt;
    logic                    lockVco;

    // Back in sysClk
    logic [1:0]              lockSync;

    // ==========================================================
    // Reference window in sysClk
    // ==========================================================

    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            refCnt <= '0;
            winTgl <= 1'b0;
        end else if (refCnt == RefCntWidth'(RefWindow - 1)) begin
            refCnt <= '0;
            winTgl <= ~winTgl;
        end else begin
            refCnt <= refCnt + 1'b1;
        end
    end

    // ==========================================================
    // VCO cycle count per window
    // ==========================================================

    always_ff @(posedge vcoClk or negedge rstN) begin
        if (!rstN) begin
            tglSync  <= '0;
            tglSyncD <= 1'b0;
        end else begin
            tglSync  <= {tglSync[0], winTgl};
            tglSyncD <= tglSync[1];
        end
    end

    // Either toggle direction ends a window
    assign winEdge = tglSync[1] ^ tglSyncD;

    always_ff @(posedge vcoClk or negedge rstN) begin
        if (!rstN) begin
            vcoCnt <= '0;
        end else if (winEdge) begin
            vcoCnt <= '0;
        end else if (vcoCnt != '1) begin
            vcoCnt <= vcoCnt + 1'b1;
        end
    end

    // Edge cycle itself belongs to the closing window
    assign winCount = (vcoCnt == '1) ? vcoCnt : vcoCnt + 1'b1;
    assign expCount = VcoCntWidth'(fbDiv) * VcoCntWidth'(RefWindow);

    // Match within one count for synchronizer jitter
    assign winGood = (fbDiv != '0) &&
                     (winCount + 1'b1 >= expCount) &&
                     (winCount <= expCount + 1'b1);

    // ==========================================================
    // Lock decision
    // ==========================================================

    always_ff @(posedge vcoClk or negedge rstN) begin
        if (!rstN) begin
            lkState  <= lkIdle;
            goodCnt  <= '0;
            winArmed <= 1'b0;
        end else if (winEdge && !winArmed) begin
            // First window after reset is partial
            winArmed <= 1'b1;
        end else if (winEdge) begin
            unique case (lkState)
                lkIdle: begin
                    if (winGood) begin
                        goodCnt <= GoodCntWidth'(1);
                        lkState <= (LockWindows <= 1) ? lkLocked : lkMeasure;
                    end
                end
                lkMeasure: begin
                    if (!winGood) begin
                        goodCnt <= '0;
                        lkState <= lkIdle;
                    end else if (goodCnt == GoodCntWidth'(LockWindows - 1)) begin
                        lkState <= lkLocked;
                    end else begin
                        goodCnt <= goodCnt + 1'b1;
                    end
                end
                lkLocked: begin
                    if (!winGood) begin
                        goodCnt <= '0;
                        lkState <= lkIdle;
                    end
                end
                default: begin
                    lkState <= lkIdle;
                end
            endcase
        end
    end

    assign lockVco = (lkState == lkLocked);

    // Two flops into sysClk and cleared while no divider is set
    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            lockSync <= '0;
        end else if (fbDiv == '0) begin
            lockSync <= '0;
        end else begin
            lockSync <= {lockSync[0], lockVco};
        end
    end

    assign lockLevel = lockSync[1];

    // Lock only rises after a nonzero divider held for the whole sync path
    assert property (@(posedge sysClk) disable iff (!rstN)
        $rose(lockLevel) |-> ($past(fbDiv, 1) != '0) && ($past(fbDiv, 2) != '0))
        else $error("pllLockDetect lock rose with zero fbDiv");

endmodule

// ==== test/clkTb.sv ====
/*
 * Testbench for the clock-control top level.
 * Runs the reference, off-chip and VCO clocks and walks the DUT through
 * reset, PLL bypass, lock, loss of lock and clock stop. The selected
 * source, the lock level and the measured output periods are compared
 * with reference functions. Prints one line per test and a count line.
 */
`timescale 1ns/1ns
module clkTb import clkPkg::*; ();

    localparam int Timeout   = 2000;
    localparam int SysPeriod = 8;
    localparam int OffPeriod = 12;

    // DUT inputs
    logic                   sysClk;
    logic                   rstN;
    logic                   offClk;
    logic                   vcoClk;
    logic                   bypAsyncFifo;
    logic                   bypPll;
    logic                   swClk;
    logic [FBDIV_WIDTH-1:0] fbDiv;

    // DUT outputs
    logic                   sysClkOut;
    logic                   offClkOut;
    logic                   pllLock;
    clkSrcE                 clkSrc;

    // VCO model changed on the falling sysClk edge
    int     vcoHalf   = 4;
    int     vcoPeriod = 8;
    int     fbDivSel  = 0;
    integer seed      = 32'h27b6;
    int     errCount   = 0;
    int     checkCount = 0;

    // Output edge timing
    time    sysRise     = 0;
    time    sysFall     = 0;
    time    offRise     = 0;
    int     sysPeriodNs = 0;
    int     offPeriodNs = 0;
    int     minPhase    = 1000;
    int     sysRiseCnt  = 0;
    int     offRiseCnt  = 0;

    clkTop clkTop_inst (
        .sysClk       (sysClk),
        .rstN         (rstN),
        .offClk       (offClk),
        .vcoClk       (vcoClk),
        .bypAsyncFifo (bypAsyncFifo),
        .bypPll       (bypPll),
        .swClk        (swClk),
        .fbDiv        (fbDiv),
        .sysClkOut    (sysClkOut),
        .offClkOut    (offClkOut),
        .pllLock      (pllLock),
        .clkSrc       (clkSrc)
    );

    // ==========================================================
    // Clocks
    // ==========================================================

    initial begin
        sysClk = 1'b0;
        forever begin
            #(SysPeriod / 2);
            sysClk = ~sysClk;
        end
    end

    // Offset of 1 ns keeps off-chip edges clear of sysClk edges
    initial begin
        offClk = 1'b0;
        #1;
        forever begin
            #(OffPeriod / 2);
            offClk = ~offClk;
        end
    end

    initial begin
        vcoClk = 1'b0;
        #1;
        forever begin
            #(vcoHalf);
            vcoClk = ~vcoClk;
        end
    end

    // ==========================================================
    // Output measurement
    // ==========================================================

    always @(posedge sysClkOut) begin
        sysPeriodNs = int'($time - sysRise);
        // Low phase just ended
        if (int'($time - sysFall) < minPhase) begin
            minPhase = int'($time - sysFall);
        end
        sysRise = $time;
        sysRiseCnt++;
    end

    always @(negedge sysClkOut) begin
        if (int'($time - sysRise) < minPhase) begin
            minPhase = int'($time - sysRise);
        end
        sysFall = $time;
    end

    always @(posedge offClkOut) begin
        offPeriodNs = int'($time - offRise);
        offRise = $time;
        offRiseCnt++;
    end

    // ==========================================================
    // Reference model
    // ==========================================================

    // Lock only when divider times VCO period gives the reference period
    function automatic bit expectedLock(int vcoPer, int div);
        return (vcoPer * div) == SysPeriod;
    endfunction

    function automatic clkSrcE expectedSrc(bit bypAf, bit bypP, bit lock);
        if (bypAf) begin
            return srcOff;
        end else if (bypP || !lock) begin
            return srcSys;
        end
        return srcPll;
    endfunction

    function automatic int expectedPeriod(clkSrcE src, int vcoPer);
        case (src)
            srcOff:  return OffPeriod;
            srcPll:  return vcoPer;
            default: return SysPeriod;
        endcase
    endfunction

    // ==========================================================
    // Compare and wait tasks
    // ==========================================================

    task automatic noteFailure(string msg);
        errCount++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic checkSrc(clkSrcE got, clkSrcE exp, string what);
        checkCount++;
        if (got !== exp) begin
            noteFailure($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic checkPeriod(int got, int exp, string what);
        checkCount++;
        if (got != exp) begin
            noteFailure($sformatf("%s is %0d ns, expected %0d ns", what, got, exp));
        end
    endtask

    task automatic checkLock(bit got, bit exp);
        checkCount++;
        if (got != exp) begin
            noteFailure($sformatf("pllLock is %0b, expected %0b", got, exp));
        end
    endtask

    // Clock output levels
    task automatic checkLevel(bit got, bit exp, string what);
        checkCount++;
        if (got != exp) begin
            noteFailure($sformatf("%s is %0b, expected %0b", what, got, exp));
        end
    endtask

    task automatic awaitSrc(clkSrcE want);
        int n;
        n = 0;
        while (clkSrc !== want && n < Timeout) begin
            @(negedge sysClk);
            n++;
        end
        if (clkSrc !== want) begin
            errCount++;
            $display("Timeout at %0t ns: clkSrc never reached %s", $time, want.name());
        end
    endtask

    task automatic awaitLock(bit want);
        int n;
        n = 0;
        while (pllLock !== want && n < Timeout) begin
            @(negedge sysClk);
            n++;
        end
        if (pllLock !== want) begin
            errCount++;
            $display("Timeout at %0t ns: pllLock never went to %0b", $time, want);
        end
    endtask

    // Waits for count rising edges of one output
    task automatic outputRises(bit offSide, int count);
        int n;
        int start;
        n = 0;
        start = offSide ? offRiseCnt : sysRiseCnt;
        while ((offSide ? offRiseCnt : sysRiseCnt) < start + count && n < Timeout) begin
            @(negedge sysClk);
            n++;
        end
        if ((offSide ? offRiseCnt : sysRiseCnt) < start + count) begin
            errCount++;
            $display("Timeout at %0t ns: %s stopped toggling", $time,
                     offSide ? "offClkOut" : "sysClkOut");
        end
    endtask

    task automatic closeTest(int num, string name, int errBefore);
        $display("Test %0d %s: %s", num, name, (errCount == errBefore) ? "ok" : "FAILED");
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial begin
        clkSrcE expSrc;
        bit     expLock;
        int     errBefore;
        int     oldHalf;
        int     shortest;
        int     stopSys;
        int     stopOff;
        rstN         = 1'b0;
        bypAsyncFifo = 1'b1;
        bypPll       = 1'b1;
        swClk        = 1'b1;
        fbDiv        = '0;

        // Test 1 covers quiet outputs in reset and then the off-chip clock
        errBefore = errCount;
        // Mid high phase of sysClk, when a leaking clock would be high
        repeat (16) begin
            @(posedge sysClk);
            #(SysPeriod / 4);
            checkLevel(sysClkOut, 1'b0, "sysClkOut in reset");
            checkLevel(offClkOut, 1'b0, "offClkOut in reset");
            checkLock(pllLock, 1'b0);
        end
        @(negedge sysClk);
        rstN = 1'b1;
        expSrc = expectedSrc(bypAsyncFifo, bypPll, expectedLock(vcoPeriod, int'(fbDiv)));
        awaitSrc(expSrc);
        outputRises(1'b0, 3);
        outputRises(1'b1, 3);
        checkSrc(clkSrc, expSrc, "clkSrc after reset");
        checkPeriod(sysPeriodNs, expectedPeriod(expSrc, vcoPeriod), "sysClkOut period");
        checkPeriod(offPeriodNs, OffPeriod, "offClkOut period");
        closeTest(1, "reset", errBefore);

        // Test 2 is the PLL bypass
        errBefore = errCount;
        @(negedge sysClk);
        bypAsyncFifo = 1'b0;
        expSrc = expectedSrc(bypAsyncFifo, bypPll, expectedLock(vcoPeriod, int'(fbDiv)));
        awaitSrc(expSrc);
        outputRises(1'b0, 3);
        checkSrc(clkSrc, expSrc, "clkSrc in PLL bypass");
        checkPeriod(sysPeriodNs, expectedPeriod(expSrc, vcoPeriod), "sysClkOut period");
        closeTest(2, "PLL bypass", errBefore);

        // Test 3 runs a matching VCO for a random divider
        errBefore = errCount;
        @(negedge sysClk);
        fbDivSel  = 1 << ($unsigned($random(seed)) % 3);
        vcoPeriod = SysPeriod / fbDivSel;
        vcoHalf   = vcoPeriod / 2;
        fbDiv     = FBDIV_WIDTH'(fbDivSel);
        bypPll    = 1'b0;
        expLock = expectedLock(vcoPeriod, fbDivSel);
        awaitLock(expLock);
        checkLock(pllLock, expLock);
        expSrc = expectedSrc(bypAsyncFifo, bypPll, expLock);
        awaitSrc(expSrc);
        outputRises(1'b0, 3);
        checkSrc(clkSrc, expSrc, "clkSrc after lock");
        checkPeriod(sysPeriodNs, expectedPeriod(expSrc, vcoPeriod), "sysClkOut period");
        closeTest(3, $sformatf("lock and switch, fbDiv %0d", fbDivSel), errBefore);

        // Test 4 lets the VCO drift off and falls back to sysClk
        errBefore = errCount;
        @(negedge sysClk);
        oldHalf   = vcoHalf;
        minPhase  = 1000;
        // 6 ns matches none of the dividers in use
        vcoPeriod = 6;
        vcoHalf   = 3;
        expLock = expectedLock(vcoPeriod, fbDivSel);
        awaitLock(expLock);
        checkLock(pllLock, expLock);
        expSrc = expectedSrc(bypAsyncFifo, bypPll, expLock);
        awaitSrc(expSrc);
        outputRises(1'b0, 3);
        checkSrc(clkSrc, expSrc, "clkSrc after loss of lock");
        checkPeriod(sysPeriodNs, expectedPeriod(expSrc, vcoPeriod), "sysClkOut period");
        shortest = SysPeriod / 2;
        if (oldHalf < shortest) begin
            shortest = oldHalf;
        end
        if (vcoHalf < shortest) begin
            shortest = vcoHalf;
        end
        checkCount++;
        if (minPhase < shortest) begin
            noteFailure($sformatf("sysClkOut phase of %0d ns, shortest half period %0d ns",
                                  minPhase, shortest));
        end
        closeTest(4, "loss of lock", errBefore);

        // Test 5 stops and restarts both outputs by software
        errBefore = errCount;
        @(negedge sysClk);
        swClk = 1'b0;
        // Release needs at most three edges of the slower gated clock
        repeat (8) @(negedge sysClk);
        stopSys = sysRiseCnt;
        stopOff = offRiseCnt;
        repeat (100) begin
            @(posedge sysClk);
            #(SysPeriod / 4);
            checkLevel(sysClkOut, 1'b0, "sysClkOut while stopped");
            checkLevel(offClkOut, 1'b0, "offClkOut while stopped");
        end
        checkCount++;
        if (sysRiseCnt != stopSys || offRiseCnt != stopOff) begin
            noteFailure("output pulsed while stopped");
        end
        @(negedge sysClk);
        swClk = 1'b1;
        outputRises(1'b1, 3);
        checkPeriod(offPeriodNs, OffPeriod, "offClkOut period after restart");
        closeTest(5, "clock stop", errBefore);

        $display("Tests: 5, checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
